//--- files.f
verilog/sbox_pkg.sv
verilog/gf_2to4_multiplier.sv
verilog/gf_2to4_inverter.sv
verilog/gf_2to8_inverter.sv
verilog/sbox_input_map.sv
verilog/sbox_output_map.sv
verilog/sbox_pipe_ctrl.sv
verilog/aes_sbox_top.sv
verif/aes_sbox_tb.sv

//--- verif/aes_sbox_tb.sv
`timescale 1ns/10ps

module aes_sbox_tb
	import sbox_pkg::*;
();

	localparam int          CLOCK_PERIOD    = 4;
	localparam int          MIXED_COUNT     = 64;
	localparam int          STALL_COUNT     = 128;
	localparam int          TOTAL_TRANSFERS = 256 + 256 + MIXED_COUNT + STALL_COUNT;
	localparam logic [31:0] LFSR_TAPS       = 32'h80200003; // x^32 + x^22 + x^2 + x + 1

	logic      clock;
	logic      reset;
	logic      req_valid;
	logic      req_ready;
	sbox_req_t req;
	logic      rsp_valid;
	logic      rsp_ready;
	byte_t     rsp_data;

	byte_t       fwd_table [256];
	byte_t       inv_table [256];
	byte_t       expected_q [$]; // Acceptance order
	int          accept_q [$];   // Cycle of each acceptance
	int          cycle_count = 0;
	logic        check_latency = 1'b0; // Only while i_ready stays high
	logic        held_valid = 1'b0;
	byte_t       held_data;
	logic [31:0] lfsr_state = 32'hb087;

	aes_sbox_top aes_sbox_top_inst
	(
		.i_clock (clock),
		.i_reset (reset),
		.i_valid (req_valid),
		.o_ready (req_ready),
		.i_req   (req),
		.o_valid (rsp_valid),
		.i_ready (rsp_ready),
		.o_data  (rsp_data)
	);

	always #(CLOCK_PERIOD / 2) clock = ~clock;

	always @(posedge clock)
		cycle_count <= cycle_count + 1;

	function automatic logic next_random_bit();
		logic out;
		out        = lfsr_state[0];
		lfsr_state = (lfsr_state >> 1) ^ (out ? LFSR_TAPS : 32'h0); // Galois step
		return out;
	endfunction

	function automatic byte_t random_byte();
		byte_t b;
		for (int i = 0; i < 8; i++)
			b[i] = next_random_bit(); // One step per bit
		return b;
	endfunction

	// Shift-and-add product mod x^8 + x^4 + x^3 + x + 1
	function automatic byte_t gf_mul(input byte_t a, input byte_t b);
		byte_t p;
		byte_t x;
		p = 8'h00;
		x = a;
		for (int i = 0; i < 8; i++)
		begin
			if (b[i])
				p ^= x;
			x = {x[6:0], 1'b0} ^ (x[7] ? 8'h1B : 8'h00); // Reduce by 0x11B
		end
		return p;
	endfunction

	function automatic byte_t gf_inverse(input byte_t a);
		for (int c = 1; c < 256; c++)
			if (gf_mul(a, byte_t'(c)) == 8'h01)
				return byte_t'(c);
		return 8'h00; // Zero has no inverse and AES maps it to zero
	endfunction

	// b ^ rotl1 ^ rotl2 ^ rotl3 ^ rotl4 ^ 0x63
	function automatic byte_t aes_affine(input byte_t b);
		byte_t r;
		byte_t rot;
		r   = b;
		rot = b;
		for (int i = 1; i < 5; i++)
		begin
			rot = {rot[6:0], rot[7]};
			r ^= rot;
		end
		return r ^ 8'h63;
	endfunction

	task automatic stop_with_failure();
		$display("Something failed");
		$fatal(1);
	endtask

	task automatic build_tables();
		for (int i = 0; i < 256; i++)
			fwd_table[i] = aes_affine(gf_inverse(byte_t'(i)));
		for (int i = 0; i < 256; i++)
			for (int j = 0; j < 256; j++)
				if (fwd_table[j] == byte_t'(i))
					inv_table[i] = byte_t'(j); // Inverse by searching the forward table
		assert (fwd_table[0] == 8'h63 && fwd_table[8'h53] == 8'hED)
		else
		begin
			$display("[ERROR] %0t reference S-box table does not hold the known values", $time);
			stop_with_failure();
		end
	endtask

	task automatic check_output();
		byte_t exp;
		int    accepted_at;
		assert (expected_q.size() > 0)
		else
		begin
			$display("[ERROR] %0t o_data %h arrived with no request outstanding", $time, rsp_data);
			stop_with_failure();
		end
		exp         = expected_q.pop_front();
		accepted_at = accept_q.pop_front();
		assert (rsp_data === exp)
		else
		begin
			$display("[ERROR] %0t o_data: got %h, expected %h", $time, rsp_data, exp);
			stop_with_failure();
		end
		if (check_latency)
		begin
			assert (cycle_count - accepted_at == 3)
			else
			begin
				$display("[ERROR] %0t latency: got %0d, expected 3", $time,
					cycle_count - accepted_at);
				stop_with_failure();
			end
		end
	endtask

	// Sampled mid-cycle before the transfer edge
	always @(negedge clock)
	begin
		if (!reset)
		begin
			if (held_valid) // Stalled last cycle
			begin
				assert (rsp_valid === 1'b1)
				else
				begin
					$display("[ERROR] %0t o_valid: got %b, expected 1 during stall",
						$time, rsp_valid);
					stop_with_failure();
				end
				assert (rsp_data === held_data)
				else
				begin
					$display("[ERROR] %0t o_data: got %h, held %h", $time, rsp_data, held_data);
					stop_with_failure();
				end
			end
			if (rsp_valid && rsp_ready)
				check_output();
			held_valid = rsp_valid && !rsp_ready;
			held_data  = rsp_data;
		end
	end

	// Called 1 ns after a rising edge and returns at the same point
	task automatic send(input sbox_req_t r, input byte_t exp);
		req_valid = 1'b1;
		req       = r;
		@(negedge clock);
		while (!req_ready)
			@(negedge clock);
		expected_q.push_back(exp);
		accept_q.push_back(cycle_count);
		@(posedge clock);
		#1;
		req_valid = 1'b0; // Next send may raise it again at once
	endtask

	task automatic wait_drain();
		while (expected_q.size() > 0)
			@(posedge clock);
		#1;
	endtask

	task automatic test_reset_state();
		@(negedge clock);
		assert (rsp_valid === 1'b0)
		else
		begin
			$display("[ERROR] %0t o_valid: got %b, expected 0", $time, rsp_valid);
			stop_with_failure();
		end
		assert (req_ready === 1'b1)
		else
		begin
			$display("[ERROR] %0t o_ready: got %b, expected 1", $time, req_ready);
			stop_with_failure();
		end
		@(posedge clock);
		#1;
	endtask

	task automatic test_forward();
		sbox_req_t r;
		for (int k = 0; k < 256; k++)
		begin
			r.data    = byte_t'(k);
			r.inverse = 1'b0;
			send(r, fwd_table[k]);
		end
		wait_drain();
	endtask

	// Feeding forward results back in must return the original byte
	task automatic test_inverse();
		sbox_req_t r;
		for (int k = 0; k < 256; k++)
		begin
			r.data    = fwd_table[k];
			r.inverse = 1'b1;
			send(r, byte_t'(k));
		end
		wait_drain();
	endtask

	task automatic test_mixed();
		sbox_req_t r;
		for (int k = 0; k < MIXED_COUNT; k++)
		begin
			r.data    = random_byte();
			r.inverse = k[0]; // Alternate modes back-to-back
			send(r, r.inverse ? inv_table[r.data] : fwd_table[r.data]);
		end
		wait_drain();
	endtask

	task automatic test_back_pressure();
		sbox_req_t r;
		int        sent;
		logic      accepted;
		sent     = 0;
		accepted = 1'b0;
		while (sent < STALL_COUNT || expected_q.size() > 0)
		begin
			if (accepted)
				req_valid = 1'b0;
			rsp_ready = next_random_bit();
			if (!req_valid && sent < STALL_COUNT && next_random_bit())
			begin
				r.data    = random_byte();
				r.inverse = next_random_bit();
				req       = r;
				req_valid = 1'b1; // Held until accepted
			end
			@(negedge clock);
			accepted = req_valid && req_ready;
			if (accepted)
			begin
				expected_q.push_back(r.inverse ? inv_table[r.data] : fwd_table[r.data]);
				accept_q.push_back(cycle_count);
				sent++;
			end
			@(posedge clock);
			#1;
		end
		req_valid = 1'b0;
		rsp_ready = 1'b1;
	endtask

	initial
	begin
		clock     = 1'b0;
		reset     = 1'b1;
		req_valid = 1'b0;
		req       = '0;
		rsp_ready = 1'b1;
		build_tables();
		repeat (10) @(posedge clock);
		#1;
		reset = 1'b0;
		test_reset_state();
		check_latency = 1'b1; // Full-rate tests
		test_forward();
		test_inverse();
		test_mixed();
		check_latency = 1'b0;
		test_back_pressure();
		$display("Everything OK");
		$finish;
	end

	// Generous bound of 20 cycles per transfer
	initial
	begin
		#(TOTAL_TRANSFERS * 20 * CLOCK_PERIOD);
		$display("[ERROR] %0t watchdog expired before the tests finished", $time);
		stop_with_failure();
	end

endmodule

//--- verilog/aes_sbox_top.sv
`timescale 1ns/10ps

module aes_sbox_top
	import sbox_pkg::*;
(
	input  logic      i_clock,
	input  logic      i_reset,
	input  logic      i_valid,
	output logic      o_ready,
	input  sbox_req_t i_req,
	output logic      o_valid,
	input  logic      i_ready,
	output byte_t     o_data
);

	localparam int MID_PIPELINED = 1; // Stage 2 sits in the inverter multipliers

	logic    enable;
	logic    out_inverse;
	nibble_t map_hi; // Stage 1 tower halves
	nibble_t map_lo;
	byte_t   inv_byte;

	sbox_pipe_ctrl u_ctrl
	(
		.i_clock       (i_clock),
		.i_reset       (i_reset),
		.i_valid       (i_valid),
		.o_ready       (o_ready),
		.i_inverse     (i_req.inverse),
		.o_valid       (o_valid),
		.i_ready       (i_ready),
		.o_enable      (enable),
		.o_out_inverse (out_inverse)
	);

	sbox_input_map u_input_map
	(
		.i_clock  (i_clock),
		.i_enable (enable),
		.i_req    (i_req),
		.o_hi     (map_hi),
		.o_lo     (map_lo)
	);

	gf_2to8_inverter #(.PIPELINED(MID_PIPELINED)) u_inverter
	(
		.i_clock  (i_clock),
		.i_enable (enable),
		.i_hi     (map_hi),
		.i_lo     (map_lo),
		.o_inv    (inv_byte)
	);

	sbox_output_map u_output_map
	(
		.i_clock   (i_clock),
		.i_enable  (enable),
		.i_inverse (out_inverse),
		.i_data    (inv_byte),
		.o_data    (o_data)
	);

endmodule

//--- verilog/gf_2to4_inverter.sv
`timescale 1ns/10ps

module gf_2to4_inverter
	import sbox_pkg::*;
(
	input  nibble_t i_x,
	output nibble_t o_inv
);

	pair_t x_h;
	pair_t x_l;
	pair_t norm;     // Lands in GF(2^2)
	pair_t norm_inv;

	assign x_h = i_x[3:2];
	assign x_l = i_x[1:0];

	// phi*h^2 + h*l + l^2
	assign norm = gf2_mul_phi(gf2_square(x_h)) ^ gf2_mul(x_h, x_l) ^ gf2_square(x_l);

	assign norm_inv = gf2_square(norm); // Zero stays zero

	// (h*y + l)^-1 = norm^-1 * (h*y + h + l)
	assign o_inv = {gf2_mul(norm_inv, x_h), gf2_mul(norm_inv, x_h ^ x_l)};

endmodule

//--- verilog/gf_2to4_multiplier.sv
`timescale 1ns/10ps

module gf_2to4_multiplier
	import sbox_pkg::*;
#(
	parameter int PIPELINED = 0 // 1 puts a register in front of the operands
)
(
	input  logic    i_clock,
	input  logic    i_enable, // Load strobe for the operand register
	input  nibble_t i_x,
	input  nibble_t i_y,
	output nibble_t o_prod
);

	nibble_t x_q; // Operands after the optional stage
	nibble_t y_q;
	pair_t   prod_h;
	pair_t   prod_hl;
	pair_t   prod_l;

	generate
		if (PIPELINED == 1)
		begin : gen_in_reg
			always_ff @(posedge i_clock)
			begin
				if (i_enable) // Holds during a stall
				begin
					x_q <= i_x;
					y_q <= i_y;
				end
			end

			assert property (@(posedge i_clock)
				i_enable && !$isunknown({i_x, i_y}) |=> !$isunknown({x_q, y_q}))
			else $error("gf_2to4_multiplier: operand register unknown after load");
		end
		else
		begin : gen_no_reg
			always_comb
			begin
				x_q = i_x;
				y_q = i_y;
			end
		end
	endgenerate

	// Karatsuba, three GF(2^2) products instead of four
	assign prod_h  = gf2_mul(x_q[3:2], y_q[3:2]);
	assign prod_hl = gf2_mul(x_q[3:2] ^ x_q[1:0], y_q[3:2] ^ y_q[1:0]);
	assign prod_l  = gf2_mul(x_q[1:0], y_q[1:0]);

	// y^2 reduces to y + phi
	assign o_prod = {prod_hl ^ prod_l, gf2_mul_phi(prod_h) ^ prod_l};

endmodule

//--- verilog/gf_2to8_inverter.sv
`timescale 1ns/10ps

module gf_2to8_inverter
	import sbox_pkg::*;
#(
	parameter int PIPELINED = 1 // Stage register inside the output multipliers
)
(
	input  logic    i_clock,
	input  logic    i_enable,
	input  nibble_t i_hi,
	input  nibble_t i_lo,
	output byte_t   o_inv
);

	nibble_t hl_prod;
	nibble_t norm;     // GF(2^4) norm of the input byte
	nibble_t norm_inv;
	nibble_t sum_hl;
	nibble_t inv_h;
	nibble_t inv_l;

	// v^2 in GF(2^4), bitwise XOR once phi folds
	function automatic nibble_t nib_square
	(
		input nibble_t v
	);
		pair_t sq_h;
		sq_h = gf2_square(v[3:2]);
		return {sq_h, gf2_mul_phi(sq_h) ^ gf2_square(v[1:0])};
	endfunction

	// v * lambda, constant product collapses to a few XORs
	function automatic nibble_t nib_scale_lambda
	(
		input nibble_t v
	);
		pair_t l_h;
		pair_t l_l;
		l_h = GF_LAMBDA[3:2];
		l_l = GF_LAMBDA[1:0];
		return {gf2_mul(v[3:2] ^ v[1:0], l_h ^ l_l) ^ gf2_mul(v[1:0], l_l),
			gf2_mul_phi(gf2_mul(v[3:2], l_h)) ^ gf2_mul(v[1:0], l_l)};
	endfunction

	gf_2to4_multiplier #(.PIPELINED(0)) u_mul_hl
	(
		.i_clock  (i_clock),
		.i_enable (i_enable),
		.i_x      (i_hi),
		.i_y      (i_lo),
		.o_prod   (hl_prod)
	);

	// lambda*h^2 + h*l + l^2
	assign norm = nib_scale_lambda(nib_square(i_hi)) ^ hl_prod ^ nib_square(i_lo);

	gf_2to4_inverter u_inv_norm
	(
		.i_x   (norm),
		.o_inv (norm_inv)
	);

	assign sum_hl = i_hi ^ i_lo;

	// Both output halves register their operands here, stage 2
	gf_2to4_multiplier #(.PIPELINED(PIPELINED)) u_mul_out_h
	(
		.i_clock  (i_clock),
		.i_enable (i_enable),
		.i_x      (norm_inv),
		.i_y      (i_hi),
		.o_prod   (inv_h)
	);

	gf_2to4_multiplier #(.PIPELINED(PIPELINED)) u_mul_out_l
	(
		.i_clock  (i_clock),
		.i_enable (i_enable),
		.i_x      (norm_inv),
		.i_y      (sum_hl),
		.o_prod   (inv_l)
	);

	assign o_inv = {inv_h, inv_l};

endmodule

//--- verilog/sbox_input_map.sv
`timescale 1ns/10ps

module sbox_input_map
	import sbox_pkg::*;
(
	input  logic      i_clock,
	input  logic      i_enable,
	input  sbox_req_t i_req,
	output nibble_t   o_hi,
	output nibble_t   o_lo
);

	// Rows listed from bit 7 down to bit 0
	localparam logic [7:0][7:0] INV_AFFINE =
		{8'h52, 8'h29, 8'h94, 8'h4A, 8'h25, 8'h92, 8'h49, 8'hA4};
	localparam byte_t           INV_AFFINE_C = 8'h05;
	// AES basis into the GF(((2^2)^2)^2) tower
	localparam logic [7:0][7:0] TO_TOWER =
		{8'hA0, 8'hDE, 8'hAC, 8'hAE, 8'hC6, 8'h9E, 8'h52, 8'h43};

	byte_t poly_in; // Still in AES basis
	byte_t tower;

	// GF(2) matrix times vector
	function automatic byte_t mat_mul
	(
		input logic [7:0][7:0] rows,
		input byte_t           v
	);
		byte_t r;
		for (int i = 0; i < 8; i++)
			r[i] = ^(rows[i] & v);
		return r;
	endfunction

	assign poly_in = i_req.inverse ? (mat_mul(INV_AFFINE, i_req.data) ^ INV_AFFINE_C)
		: i_req.data;
	assign tower = mat_mul(TO_TOWER, poly_in);

	// Stage 1
	always_ff @(posedge i_clock)
	begin
		if (i_enable)
		begin
			o_hi <= tower[7:4];
			o_lo <= tower[3:0];
		end
	end

endmodule

//--- verilog/sbox_output_map.sv
`timescale 1ns/10ps

module sbox_output_map
	import sbox_pkg::*;
(
	input  logic  i_clock,
	input  logic  i_enable,
	input  logic  i_inverse, // Mode of the item leaving stage 2
	input  byte_t i_data,    // Tower basis
	output byte_t o_data
);

	// Tower back to AES basis, bit 7 row first
	localparam logic [7:0][7:0] FROM_TOWER =
		{8'hE2, 8'h44, 8'h62, 8'h76, 8'h3E, 8'h9E, 8'h30, 8'h75};
	localparam logic [7:0][7:0] AFFINE =
		{8'hF8, 8'h7C, 8'h3E, 8'h1F, 8'h8F, 8'hC7, 8'hE3, 8'hF1};
	localparam byte_t           AFFINE_C = 8'h63;

	byte_t poly;
	byte_t result;

	function automatic byte_t mat_mul
	(
		input logic [7:0][7:0] rows,
		input byte_t           v
	);
		byte_t r;
		for (int i = 0; i < 8; i++)
			r[i] = ^(rows[i] & v);
		return r;
	endfunction

	assign poly   = mat_mul(FROM_TOWER, i_data);
	// Inverse S-box ends at the field inverse
	assign result = i_inverse ? poly : (mat_mul(AFFINE, poly) ^ AFFINE_C);

	// Stage 3, drives the output port directly
	always_ff @(posedge i_clock)
	begin
		if (i_enable)
			o_data <= result;
	end

endmodule

//--- verilog/sbox_pipe_ctrl.sv
`timescale 1ns/10ps

module sbox_pipe_ctrl
(
	input  logic i_clock,
	input  logic i_reset,
	input  logic i_valid,
	output logic o_ready,
	input  logic i_inverse,    // Mode of the incoming request
	output logic o_valid,
	input  logic i_ready,
	output logic o_enable,     // Shared by every stage register
	output logic o_out_inverse // Mode in front of the output map
);

	typedef struct packed
	{
		logic valid;
		logic inverse;
	} stage_t;

	stage_t [3:1] stage_q; // Index matches the pipeline stage

	// Whole pipe moves or none of it
	assign o_enable      = ~stage_q[3].valid | i_ready;
	assign o_ready       = o_enable;
	assign o_valid       = stage_q[3].valid;
	assign o_out_inverse = stage_q[2].inverse;

	always_ff @(posedge i_clock)
	begin
		if (i_reset)
		begin
			stage_q <= '0;
		end
		else if (o_enable)
		begin
			stage_q[1] <= '{valid: i_valid, inverse: i_inverse};
			stage_q[2] <= stage_q[1];
			stage_q[3] <= stage_q[2];
		end
	end

	// Stalled result must wait with its mode intact
	assert property (@(posedge i_clock) disable iff (i_reset)
		o_valid && !i_ready |=> o_valid && $stable(stage_q[3].inverse))
	else $error("sbox_pipe_ctrl: stalled result dropped or mode changed");

	assert property (@(posedge i_clock) disable iff (i_reset)
		!o_valid |-> o_ready)
	else $error("sbox_pipe_ctrl: input blocked with empty output stage");

endmodule

//--- verilog/sbox_pkg.sv
package sbox_pkg;

	// Field widths
	localparam int NB_BYTE   = 8;
	localparam int NB_NIBBLE = 4;
	localparam int NB_PAIR   = 2;

	typedef logic [NB_BYTE-1:0]   byte_t;   // GF(2^8) element
	typedef logic [NB_NIBBLE-1:0] nibble_t; // GF(2^4) element, tower basis {hi, lo}
	typedef logic [NB_PAIR-1:0]   pair_t;   // GF(2^2) element, {w, 1} basis

	// One request on the input handshake
	typedef struct packed
	{
		byte_t data;    // AES polynomial basis
		logic  inverse; // 1 selects the inverse S-box
	} sbox_req_t;

	// GF(2^4) = GF(2^2)[y] / (y^2 + y + phi)
	localparam pair_t   GF_PHI    = 2'b10;
	// GF(2^8) = GF(2^4)[z] / (z^2 + z + lambda)
	localparam nibble_t GF_LAMBDA = 4'b1100;

	// GF(2^2) product, w^2 = w + 1
	function automatic pair_t gf2_mul
	(
		input pair_t a,
		input pair_t b
	);
		pair_t p;
		p[1] = (a[1] & b[1]) ^ (a[1] & b[0]) ^ (a[0] & b[1]);
		p[0] = (a[1] & b[1]) ^ (a[0] & b[0]);
		return p;
	endfunction

	// Constant operand folds down to two XOR inputs
	function automatic pair_t gf2_mul_phi
	(
		input pair_t a
	);
		return gf2_mul(a, GF_PHI);
	endfunction

	// Also the inverse in GF(2^2), since a^3 = 1 for a != 0
	function automatic pair_t gf2_square
	(
		input pair_t a
	);
		return {a[1], a[1] ^ a[0]};
	endfunction

endpackage
